// File: list.f
rtl/cache_pkg.sv
rtl/dcache_array.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
sim/mem_model.sv
sim/dcache_checker.sv
sim/tb_dcache.sv

// File: rtl/cache_pkg.sv
// data cache shared definitions
package cache_pkg;

  // geometry
  localparam int WORD_W    = 32;
  localparam int WAYS      = 2;
  localparam int SETS      = 8;
  localparam int IDX_W     = 3;   // address bits 5:3
  localparam int TAG_W     = 26;  // address bits 31:6
  localparam int BLK_WORDS = 2;   // address bit 2 picks the word

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [IDX_W-1:0]  idx_t;

  // controller states
  typedef enum logic [3:0] {
    IDLE,
    FILL0,        // fetch word 0 of the missing block
    FILL1,        // fetch word 1, then install tag
    WB0,          // victim write-back, word 0
    WB1,
    FLUSH_SCAN,   // look at one line per cycle
    FLUSH_WB0,
    FLUSH_WB1,
    FLUSHED,      // parked until reset
    SNOOP,
    SNOOP_WB0,
    SNOOP_WB1,
    SNOOP_HOLD    // cctrans up, wait for the bus to let go
  } ctrl_state_t;

endpackage

// File: rtl/dcache_array.sv
// data cache line storage
module dcache_array
  import cache_pkg::*;
(
  input  logic                    CLK,
  input  logic                    nRST,
  // lookups
  input  idx_t                    query_idx,
  input  tag_t                    query_tag,
  input  idx_t                    snoop_idx,
  input  tag_t                    snoop_tag,
  input  logic                    flush_way,
  input  idx_t                    flush_idx,
  // updates
  input  logic                    wr_way,
  input  idx_t                    wr_idx,
  input  logic                    wr_word,
  input  word_t                   wr_data,
  input  logic                    wr_en,
  input  logic                    tag_en,
  input  tag_t                    new_tag,
  input  logic                    set_valid,
  input  logic                    set_dirty,
  input  logic                    clr_dirty,
  input  logic                    inv_en,
  input  logic                    inv_way,
  input  idx_t                    inv_idx,
  input  logic                    lru_touch,
  input  logic                    lru_way,
  // query side
  output logic                    query_hit,
  output logic                    query_way,
  output logic                    victim_way,
  output logic                    victim_valid,
  output logic                    victim_dirty,
  output tag_t                    victim_tag,
  output word_t [BLK_WORDS-1:0]   victim_data,
  output word_t                   hit_data,
  // snoop side
  output logic                    snoop_hit,
  output logic                    snoop_way,
  output logic                    snoop_dirty,
  output word_t [BLK_WORDS-1:0]   snoop_data,
  // flush walk
  output logic                    flush_valid,
  output logic                    flush_dirty,
  output tag_t                    flush_tag,
  output word_t [BLK_WORDS-1:0]   flush_data
);

  tag_t            tags [WAYS][SETS];
  word_t           data [WAYS][SETS][BLK_WORDS];
  logic [SETS-1:0] valid [WAYS];
  logic [SETS-1:0] dirty [WAYS];
  logic [SETS-1:0] lru;             // per set, the way to evict next
  logic [WAYS-1:0] q_match;
  logic [WAYS-1:0] s_match;

  // tag compare for both lookup ports
  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      q_match[w] = valid[w][query_idx] && (tags[w][query_idx] == query_tag);
      s_match[w] = valid[w][snoop_idx] && (tags[w][snoop_idx] == snoop_tag);
    end
  end

  assign query_hit    = |q_match;
  assign query_way    = q_match[1];
  assign hit_data     = data[query_way][query_idx][wr_word];  // word select shared with writes

  assign victim_way   = lru[query_idx];
  assign victim_valid = valid[victim_way][query_idx];
  assign victim_dirty = dirty[victim_way][query_idx];
  assign victim_tag   = tags[victim_way][query_idx];

  assign snoop_hit    = |s_match;
  assign snoop_way    = s_match[1];
  assign snoop_dirty  = dirty[snoop_way][snoop_idx];

  assign flush_valid  = valid[flush_way][flush_idx];
  assign flush_dirty  = dirty[flush_way][flush_idx];
  assign flush_tag    = tags[flush_way][flush_idx];

  always_comb begin
    for (int b = 0; b < BLK_WORDS; b++) begin
      victim_data[b] = data[victim_way][query_idx][b];
      snoop_data[b]  = data[snoop_way][snoop_idx][b];
      flush_data[b]  = data[flush_way][flush_idx][b];
    end
  end

  // line status and lru
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int w = 0; w < WAYS; w++) begin
        valid[w] <= '0;
        dirty[w] <= '0;
      end
      lru <= '0;
    end else begin
      if (set_valid) valid[wr_way][wr_idx] <= 1'b1;
      if (set_dirty) dirty[wr_way][wr_idx] <= 1'b1;
      if (clr_dirty) dirty[wr_way][wr_idx] <= 1'b0;
      if (inv_en) begin
        valid[inv_way][inv_idx] <= 1'b0;
        dirty[inv_way][inv_idx] <= 1'b0;
      end
      if (lru_touch) lru[wr_idx] <= ~lru_way;  // other way goes next
    end
  end

  // tag and data payload
  always_ff @(posedge CLK) begin
    if (wr_en) data[wr_way][wr_idx][wr_word] <= wr_data;
    if (tag_en) tags[wr_way][wr_idx] <= new_tag;
  end

endmodule

// File: rtl/dcache_ctrl.sv
// data cache controller
module dcache_ctrl
  import cache_pkg::*;
(
  input  logic                    CLK,
  input  logic                    nRST,
  // datapath
  input  logic                    dmem_ren,
  input  logic                    dmem_wen,
  input  word_t                   dmem_addr,
  input  word_t                   dmem_store,
  input  logic                    halt,
  output logic                    dhit,
  output word_t                   dmem_load,
  output logic                    flushed,
  // memory
  output logic                    mem_ren,
  output logic                    mem_wen,
  output word_t                   mem_addr,
  output word_t                   mem_store,
  input  word_t                   mem_load,
  input  logic                    mem_wait,
  // coherence bus
  input  logic                    ccwait,
  input  word_t                   ccsnoop_addr,
  input  logic                    ccinv,
  output logic                    cctrans,
  output logic                    ccwrite,
  // array lookups
  input  logic                    query_hit,
  input  logic                    query_way,
  input  logic                    victim_way,
  input  logic                    victim_valid,
  input  logic                    victim_dirty,
  input  tag_t                    victim_tag,
  input  word_t [BLK_WORDS-1:0]   victim_data,
  input  word_t                   hit_data,
  input  logic                    snoop_hit,
  input  logic                    snoop_way,
  input  logic                    snoop_dirty,
  input  word_t [BLK_WORDS-1:0]   snoop_data,
  input  logic                    flush_valid,
  input  logic                    flush_dirty,
  input  tag_t                    flush_tag,
  input  word_t [BLK_WORDS-1:0]   flush_data,
  // array controls
  output idx_t                    query_idx,
  output tag_t                    query_tag,
  output idx_t                    snoop_idx,
  output tag_t                    snoop_tag,
  output logic                    flush_way,
  output idx_t                    flush_idx,
  output logic                    wr_way,
  output idx_t                    wr_idx,
  output logic                    wr_word,
  output word_t                   wr_data,
  output logic                    wr_en,
  output logic                    tag_en,
  output tag_t                    new_tag,
  output logic                    set_valid,
  output logic                    set_dirty,
  output logic                    clr_dirty,
  output logic                    inv_en,
  output logic                    inv_way,
  output idx_t                    inv_idx,
  output logic                    lru_touch,
  output logic                    lru_way
);

  ctrl_state_t state, state_nxt;
  logic [3:0]  line_cnt, line_cnt_nxt;  // {way, set} during the flush walk
  logic        cctrans_nxt;
  logic        ccwrite_nxt;
  logic        q_word;

  // address split
  assign query_tag = dmem_addr[WORD_W-1 -: TAG_W];
  assign query_idx = dmem_addr[3 +: IDX_W];
  assign q_word    = dmem_addr[2];
  assign snoop_tag = ccsnoop_addr[WORD_W-1 -: TAG_W];
  assign snoop_idx = ccsnoop_addr[3 +: IDX_W];

  assign flush_way = line_cnt[3];
  assign flush_idx = line_cnt[2:0];

  assign dmem_load = hit_data;
  assign flushed   = (state == FLUSHED);
  assign new_tag   = query_tag;  // only fills install tags
  assign inv_way   = snoop_way;
  assign inv_idx   = snoop_idx;
  assign lru_way   = query_way;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state    <= IDLE;
      line_cnt <= '0;
      cctrans  <= 1'b0;
      ccwrite  <= 1'b0;
    end else begin
      state    <= state_nxt;
      line_cnt <= line_cnt_nxt;
      cctrans  <= cctrans_nxt;
      ccwrite  <= ccwrite_nxt;
    end
  end

  always_comb begin
    state_nxt    = state;
    line_cnt_nxt = line_cnt;
    cctrans_nxt  = cctrans;
    ccwrite_nxt  = ccwrite;
    dhit         = 1'b0;
    mem_ren      = 1'b0;
    mem_wen      = 1'b0;
    mem_addr     = '0;
    mem_store    = '0;
    wr_way       = victim_way;   // fills land in the lru way
    wr_idx       = query_idx;
    wr_word      = q_word;
    wr_data      = mem_load;
    wr_en        = 1'b0;
    tag_en       = 1'b0;
    set_valid    = 1'b0;
    set_dirty    = 1'b0;
    clr_dirty    = 1'b0;
    inv_en       = 1'b0;
    lru_touch    = 1'b0;

    case (state)
      IDLE: begin
        wr_way  = query_way;
        wr_data = dmem_store;
        if (ccwait) begin
          state_nxt = SNOOP;  // snoop wins over the datapath
        end else if (dmem_ren || dmem_wen) begin
          if (query_hit) begin
            dhit      = 1'b1;
            lru_touch = 1'b1;
            wr_en     = dmem_wen;
            set_dirty = dmem_wen;
          end else if (victim_valid && victim_dirty) begin
            state_nxt = WB0;
          end else begin
            state_nxt = FILL0;
          end
        end else if (halt) begin
          state_nxt = FLUSH_SCAN;
        end
      end

      WB0: begin
        mem_wen   = 1'b1;
        mem_addr  = {victim_tag, query_idx, 3'b000};
        mem_store = victim_data[0];
        if (!mem_wait) begin
          state_nxt = WB1;
        end
      end

      WB1: begin
        mem_wen   = 1'b1;
        mem_addr  = {victim_tag, query_idx, 3'b100};
        mem_store = victim_data[1];
        if (!mem_wait) begin
          state_nxt = FILL0;
        end
      end

      FILL0: begin
        mem_ren  = 1'b1;
        mem_addr = {query_tag, query_idx, 3'b000};
        wr_word  = 1'b0;
        if (!mem_wait) begin
          wr_en     = 1'b1;
          state_nxt = FILL1;
        end
      end

      FILL1: begin
        mem_ren  = 1'b1;
        mem_addr = {query_tag, query_idx, 3'b100};
        wr_word  = 1'b1;
        if (!mem_wait) begin
          wr_en     = 1'b1;
          tag_en    = 1'b1;
          set_valid = 1'b1;
          clr_dirty = 1'b1;  // fresh block matches memory
          state_nxt = IDLE;  // request hits next cycle
        end
      end

      // walk all 16 lines, way 0 first
      FLUSH_SCAN: begin
        if (flush_valid && flush_dirty) begin
          state_nxt = FLUSH_WB0;
        end else if (line_cnt == 4'd15) begin
          state_nxt = FLUSHED;
        end else begin
          line_cnt_nxt = line_cnt + 4'd1;
        end
      end

      FLUSH_WB0: begin
        mem_wen   = 1'b1;
        mem_addr  = {flush_tag, flush_idx, 3'b000};
        mem_store = flush_data[0];
        if (!mem_wait) begin
          state_nxt = FLUSH_WB1;
        end
      end

      FLUSH_WB1: begin
        mem_wen   = 1'b1;
        mem_addr  = {flush_tag, flush_idx, 3'b100};
        mem_store = flush_data[1];
        if (!mem_wait) begin
          if (line_cnt == 4'd15) begin
            state_nxt = FLUSHED;
          end else begin
            line_cnt_nxt = line_cnt + 4'd1;
            state_nxt    = FLUSH_SCAN;
          end
        end
      end

      FLUSHED: begin
        state_nxt = FLUSHED;
      end

      SNOOP: begin
        if (snoop_hit && snoop_dirty) begin
          ccwrite_nxt = 1'b1;  // we supply the block
          state_nxt   = SNOOP_WB0;
        end else begin
          inv_en      = snoop_hit && ccinv;
          cctrans_nxt = 1'b1;
          state_nxt   = SNOOP_HOLD;
        end
      end

      SNOOP_WB0: begin
        mem_wen   = 1'b1;
        mem_addr  = {snoop_tag, snoop_idx, 3'b000};
        mem_store = snoop_data[0];
        if (!mem_wait) begin
          state_nxt = SNOOP_WB1;
        end
      end

      SNOOP_WB1: begin
        wr_way    = snoop_way;
        wr_idx    = snoop_idx;
        mem_wen   = 1'b1;
        mem_addr  = {snoop_tag, snoop_idx, 3'b100};
        mem_store = snoop_data[1];
        if (!mem_wait) begin
          inv_en      = ccinv;
          clr_dirty   = !ccinv;  // kept lines turn clean
          cctrans_nxt = 1'b1;
          state_nxt   = SNOOP_HOLD;
        end
      end

      SNOOP_HOLD: begin
        if (!ccwait) begin
          cctrans_nxt = 1'b0;
          ccwrite_nxt = 1'b0;
          state_nxt   = IDLE;
        end
      end

      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

endmodule

// File: rtl/dcache_top.sv
// data cache top level
module dcache_top
  import cache_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  // datapath
  input  logic  dmem_ren,
  input  logic  dmem_wen,
  input  word_t dmem_addr,
  input  word_t dmem_store,
  input  logic  halt,
  output logic  dhit,
  output word_t dmem_load,
  output logic  flushed,
  // memory
  output logic  mem_ren,
  output logic  mem_wen,
  output word_t mem_addr,
  output word_t mem_store,
  input  word_t mem_load,
  input  logic  mem_wait,
  // coherence bus
  input  logic  ccwait,
  input  word_t ccsnoop_addr,
  input  logic  ccinv,
  output logic  cctrans,
  output logic  ccwrite
);

  // array to controller
  logic                  query_hit, query_way;
  logic                  victim_way, victim_valid, victim_dirty;
  tag_t                  victim_tag;
  word_t [BLK_WORDS-1:0] victim_data;
  word_t                 hit_data;
  logic                  snoop_hit, snoop_way, snoop_dirty;
  word_t [BLK_WORDS-1:0] snoop_data;
  logic                  flush_valid, flush_dirty;
  tag_t                  flush_tag;
  word_t [BLK_WORDS-1:0] flush_data;

  // controller to array
  idx_t                  query_idx, snoop_idx, flush_idx, wr_idx, inv_idx;
  tag_t                  query_tag, snoop_tag, new_tag;
  logic                  flush_way, wr_way, wr_word, inv_way, lru_way;
  word_t                 wr_data;
  logic                  wr_en, tag_en, set_valid, set_dirty, clr_dirty;
  logic                  inv_en, lru_touch;

  dcache_array i_array (.*);

  dcache_ctrl i_ctrl (.*);

endmodule

// File: sim/dcache_checker.sv
// data cache checker
module dcache_checker
  import cache_pkg::*;
#(
  parameter word_t ADDR_BASE = 32'h0000_4000,
  parameter int    N_WORDS   = 64
) (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  dmem_ren,
  input  logic  dmem_wen,
  input  word_t dmem_addr,
  input  word_t dmem_store,
  input  logic  dhit,
  input  word_t dmem_load,
  input  logic  flushed,
  input  logic  mem_ren,
  input  logic  mem_wen,
  input  word_t mem_addr,
  input  word_t mem_store,
  input  logic  mem_wait,
  input  logic  ccwait,
  input  word_t ccsnoop_addr,
  input  logic  cctrans,
  input  logic  ccwrite,
  input  logic  ext_write,
  input  word_t ext_addr,
  input  word_t ext_data0,
  input  word_t ext_data1,
  input  word_t peek_data,
  output word_t peek_addr,
  output logic  check_done,
  output int    read_errs,
  output int    mem_errs,
  output int    proto_errs
);

  word_t shadow [N_WORDS];    // what memory should hold once all dirty lines are back
  word_t mem_copy [N_WORDS];  // what the model memory holds right now
  int    fills;               // fill reads in the current request
  int    snoop_wr;            // memory writes in the current snoop
  logic  snoop_stale;         // snooped block is newer in the cache than in memory
  logic  prev_ccwait;
  logic  prev_cctrans;
  logic  flush_seen;

  function automatic word_t fill_pattern(word_t a);
    return (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
  endfunction

  function automatic int word_index(word_t a);
    return int'((a - ADDR_BASE) >> 2);
  endfunction

  initial begin
    for (int i = 0; i < N_WORDS; i++) begin
      shadow[i]   = fill_pattern(ADDR_BASE + 4 * i);
      mem_copy[i] = shadow[i];
    end
    fills        = 0;
    snoop_wr     = 0;
    snoop_stale  = 1'b0;
    prev_ccwait  = 1'b0;
    prev_cctrans = 1'b0;
    flush_seen   = 1'b0;
    check_done   = 1'b0;
    read_errs    = 0;
    mem_errs     = 0;
    proto_errs   = 0;
    peek_addr    = ADDR_BASE;
  end

  // walk the model memory through the peek port
  task automatic compare_memory();
    word_t a;
    for (int i = 0; i < N_WORDS; i++) begin
      a         = ADDR_BASE + 4 * i;
      peek_addr = a;
      #1;
      if (peek_data !== shadow[i]) begin
        mem_errs++;
        $display("Fail %0t: memory at %h holds %h, expected %h", $time, a, peek_data, shadow[i]);
      end
    end
  endtask

  always @(negedge CLK) begin : watch
    word_t exp;
    int    blk;
    if (!nRST) begin
      if (dhit || flushed || mem_ren || mem_wen || cctrans || ccwrite) begin
        proto_errs++;
        $display("outputs are not low during reset at time %0t", $time);
      end
    end else begin
      if (ext_write) begin
        shadow[word_index(ext_addr)]       = ext_data0;
        shadow[word_index(ext_addr) + 1]   = ext_data1;
        mem_copy[word_index(ext_addr)]     = ext_data0;
        mem_copy[word_index(ext_addr) + 1] = ext_data1;
      end
      if (dhit) begin
        if (mem_ren || mem_wen) begin
          proto_errs++;
          $display("memory request during a hit at time %0t", $time);
        end
        if (fills != 0 && fills != 2) begin
          proto_errs++;
          $display("request finished after %0d fill reads at time %0t", fills, $time);
        end
        fills = 0;
        if (dmem_ren) begin
          exp = shadow[word_index(dmem_addr)];
          if (dmem_load !== exp) begin
            read_errs++;
            $display("Fail %0t: read of %h returned %h, expected %h",
                     $time, dmem_addr, dmem_load, exp);
          end
        end else if (dmem_wen) begin
          shadow[word_index(dmem_addr)] = dmem_store;
        end
      end
      // fills read the requested block, word 0 first
      if (mem_ren && !mem_wait) begin
        exp = {dmem_addr[31:3], fills[0], 2'b00};
        if (!(dmem_ren || dmem_wen) || mem_addr !== exp) begin
          mem_errs++;
          $display("Fail %0t: fill read from %h, expected %h", $time, mem_addr, exp);
        end
        fills++;
      end
      if (ccwait && !prev_ccwait) begin
        blk         = word_index(ccsnoop_addr) & ~1;
        snoop_wr    = 0;
        snoop_stale = (shadow[blk] !== mem_copy[blk]) ||
                      (shadow[blk + 1] !== mem_copy[blk + 1]);
      end
      if (mem_wen && !mem_wait) begin
        exp = shadow[word_index(mem_addr)];
        if (mem_store !== exp) begin
          mem_errs++;
          $display("Fail %0t: write-back to %h carries %h, expected %h",
                   $time, mem_addr, mem_store, exp);
        end
        mem_copy[word_index(mem_addr)] = mem_store;
        if (ccwait) begin
          snoop_wr++;
          if (!ccwrite || mem_addr[31:3] !== ccsnoop_addr[31:3]) begin
            proto_errs++;
            $display("snoop write to %h lacks ccwrite or misses the block at time %0t",
                     mem_addr, $time);
          end
        end
      end
      if (prev_ccwait && !ccwait) begin
        if ((snoop_wr != 0 && snoop_wr != 2) || ccwrite !== (snoop_wr == 2)) begin
          proto_errs++;
          $display("snoop wrote %0d words with ccwrite %b at time %0t", snoop_wr, ccwrite, $time);
        end
        if (snoop_stale && snoop_wr != 2) begin
          proto_errs++;
          $display("dirty block %h was not written back on the snoop at time %0t",
                   ccsnoop_addr, $time);
        end
      end
      if (prev_cctrans && !cctrans && prev_ccwait) begin
        proto_errs++;
        $display("cctrans fell while ccwait was still high at time %0t", $time);
      end
      if (cctrans && !ccwait && !prev_ccwait) begin
        proto_errs++;
        $display("cctrans stayed high after the snoop ended at time %0t", $time);
      end
      if (flush_seen && !flushed) begin
        proto_errs++;
        $display("flushed fell after rising at time %0t", $time);
      end
      prev_ccwait  = ccwait;
      prev_cctrans = cctrans;
      if (flushed && !flush_seen) begin
        flush_seen = 1'b1;
        compare_memory();
        check_done = 1'b1;
      end
    end
  end

endmodule

// File: sim/mem_model.sv
// word memory model
module mem_model
  import cache_pkg::*;
#(
  parameter word_t SEED      = 32'd55,
  parameter word_t ADDR_BASE = 32'h0000_4000,
  parameter int    N_WORDS   = 64
) (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  mem_ren,
  input  logic  mem_wen,
  input  word_t mem_addr,
  input  word_t mem_store,
  output word_t mem_load,
  output logic  mem_wait,
  input  logic  ccwait,
  input  word_t ccsnoop_addr,
  input  logic  ccinv,
  input  logic  cctrans,
  output logic  ext_write,   // one-cycle pulse per external block write
  output word_t ext_addr,
  output word_t ext_data0,
  output word_t ext_data1,
  input  word_t peek_addr,
  output word_t peek_data
);

  word_t      mem [N_WORDS];
  word_t      rnd;
  logic [1:0] wait_cnt;   // waits left before the current transfer completes
  word_t      mem_idx;
  word_t      snoop_idx;

  function automatic word_t xorshift32(word_t x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic word_t fill_pattern(word_t a);
    return (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
  endfunction

  initial begin
    for (int i = 0; i < N_WORDS; i++) begin
      mem[i] = fill_pattern(ADDR_BASE + 4 * i);
    end
  end

  assign mem_idx   = (mem_addr - ADDR_BASE) >> 2;
  assign snoop_idx = ((ccsnoop_addr - ADDR_BASE) >> 2) & ~32'd1;  // word 0 of the block
  assign mem_load  = mem[mem_idx];
  assign peek_data = mem[(peek_addr - ADDR_BASE) >> 2];
  assign mem_wait  = (mem_ren || mem_wen) && (wait_cnt != 2'd0);

  always @(posedge CLK or negedge nRST) begin : seq
    word_t r;
    word_t d0;
    if (!nRST) begin
      rnd       <= SEED;
      wait_cnt  <= 2'd0;
      ext_write <= 1'b0;
      ext_addr  <= '0;
      ext_data0 <= '0;
      ext_data1 <= '0;
    end else begin
      r = rnd;
      ext_write <= 1'b0;
      if (mem_ren || mem_wen) begin
        if (wait_cnt != 2'd0) begin
          wait_cnt <= wait_cnt - 2'd1;
        end else begin
          if (mem_wen && mem_idx < N_WORDS) mem[mem_idx] <= mem_store;  // stray writes dropped
          wait_cnt <= r[1:0];  // 0 to 3 waits for the next transfer
          r = xorshift32(r);
        end
      end
      // the other core writes the block once the invalidating snoop is done
      if (ccwait && ccinv && cctrans) begin
        d0 = r;
        r  = xorshift32(r);
        mem[snoop_idx]     <= d0;
        mem[snoop_idx + 1] <= r;
        ext_write <= 1'b1;
        ext_addr  <= {ccsnoop_addr[31:3], 3'b000};
        ext_data0 <= d0;
        ext_data1 <= r;
        r = xorshift32(r);
      end
      rnd <= r;
    end
  end

endmodule

// File: sim/tb_dcache.sv
// data cache testbench
module tb_dcache
  import cache_pkg::*;
();

  localparam word_t SEED            = 32'd55;
  localparam int    N_OPS           = 400;
  localparam int    N_WORDS         = 64;             // 4 tags per set, 2 ways
  localparam word_t ADDR_BASE       = 32'h0000_4000;
  localparam int    CLK_PERIOD      = 100;
  localparam int    RESET_CYCLES    = 16;
  localparam int    WATCHDOG_CYCLES = RESET_CYCLES + N_OPS * 40;

  logic  CLK = 1'b0;
  logic  nRST;
  logic  dmem_ren, dmem_wen, halt, dhit, flushed;
  word_t dmem_addr, dmem_store, dmem_load;
  logic  mem_ren, mem_wen, mem_wait;
  word_t mem_addr, mem_store, mem_load;
  logic  ccwait, ccinv, cctrans, ccwrite;
  word_t ccsnoop_addr;
  logic  ext_write;
  word_t ext_addr, ext_data0, ext_data1, peek_addr, peek_data;
  logic  check_done;
  int    read_errs, mem_errs, proto_errs;
  word_t rnd_state;

  dcache_top i_dcache_top (.*);

  mem_model #(.SEED(SEED), .ADDR_BASE(ADDR_BASE), .N_WORDS(N_WORDS)) i_mem (.*);

  dcache_checker #(.ADDR_BASE(ADDR_BASE), .N_WORDS(N_WORDS)) i_check (.*);

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  function automatic word_t xorshift32(word_t x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // hold the request until dhit, then drop it
  task automatic datapath_access(input logic write, input word_t addr, input word_t data);
    dmem_ren   = !write;
    dmem_wen   = write;
    dmem_addr  = addr;
    dmem_store = data;
    @(negedge CLK);
    while (!dhit) @(negedge CLK);
    @(posedge CLK);
    #10;
    dmem_ren = 1'b0;
    dmem_wen = 1'b0;
  endtask

  task automatic snoop_block(input word_t addr, input logic inv);
    ccwait       = 1'b1;
    ccsnoop_addr = addr;
    ccinv        = inv;
    @(negedge CLK);
    while (!cctrans) @(negedge CLK);
    @(posedge CLK);
    #10;
    ccwait = 1'b0;
    ccinv  = 1'b0;
    @(negedge CLK);
    while (cctrans) @(negedge CLK);  // cache back in IDLE
    @(posedge CLK);
    #10;
  endtask

  initial begin : stimulus
    word_t r;
    word_t addr;
    nRST         = 1'b0;
    dmem_ren     = 1'b0;
    dmem_wen     = 1'b0;
    dmem_addr    = '0;
    dmem_store   = '0;
    halt         = 1'b0;
    ccwait       = 1'b0;
    ccsnoop_addr = '0;
    ccinv        = 1'b0;
    rnd_state    = SEED;
    repeat (RESET_CYCLES) @(posedge CLK);
    #10;
    nRST = 1'b1;
    for (int i = 0; i < N_OPS; i++) begin
      rnd_state = xorshift32(rnd_state);
      r         = rnd_state;
      addr      = ADDR_BASE + {r[7:2], 2'b00};
      if (r[31:29] == 3'd0) begin
        snoop_block(addr, r[28]);  // about one op in eight
      end else if (r[27]) begin
        rnd_state = xorshift32(rnd_state);
        datapath_access(1'b1, addr, rnd_state);
      end else begin
        datapath_access(1'b0, addr, '0);
      end
    end
    halt = 1'b1;
    @(negedge CLK);
    while (!check_done) @(negedge CLK);
    repeat (4) @(negedge CLK);  // flushed has to stay up
    $display("errors: read data %0d, memory data %0d, protocol %0d",
             read_errs, mem_errs, proto_errs);
    if (read_errs + mem_errs + proto_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

endmodule
